/* verilog.f */
+incdir+hw
hw/tx_stream_pkg.sv
hw/tx_status_pkg.sv
hw/setting_reg.sv
hw/vita_timekeeper.sv
hw/dsp_strobe_gen.sv
hw/tx_control.sv
hw/tx_core.sv
tests/tx_core_assert.sv
tests/tx_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the transmit core testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tx_core_tb \
   -f verilog.f -o tx_core_sim > build.log 2>&1 &&
./obj_dir/tx_core_sim > sim.log 2>&1 &&
grep -qx "Done: no errors" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* tests/tx_core_tb.sv */
// ******************************
// Transmit core testbench. Directed
// burst, timing and error tests.
// ******************************
`include "tx_defs.svh"

module tx_core_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import tx_stream_pkg::*;

   localparam int timeout_cycles = 300;

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  clear;
   logic                  set_stb;
   logic [`SR_ADDR_W-1:0] set_addr;
   logic [`SR_DATA_W-1:0] set_data;
   sample_t               tx_tdata;
   tuser_t                tx_tuser;
   logic                  tx_tlast;
   logic                  tx_tvalid;
   logic                  tx_tready;
   logic                  run;
   sample_t               sample;
   logic                  error;
   logic [63:0]           error_code;
   seqnum_t               seqnum;

   integer     seed = 32'he5aa_816d;
   int         error_count = 0;
   int         check_count = 0;
   sample_t    played_q[$];
   sample_t    expect_q[$];
   logic [63:0] code_q[$];
   logic       run_last = 1'b0;
   vita_time_t run_rise_time;

   always #20 clk = ~clk;

   tx_core UUT
   (
      .clk(clk), .reset(reset), .clear(clear),
      .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
      .tx_tdata(tx_tdata), .tx_tuser(tx_tuser), .tx_tlast(tx_tlast),
      .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .run(run), .sample(sample),
      .error(error), .error_code(error_code), .seqnum(seqnum)
   );

   // Pre-edge view of what the DSP core gets.
   always @(posedge clk)
   begin
      if (run && tx_tready && tx_tvalid)
         played_q.push_back(sample);
      if (error)
         code_q.push_back(error_code);
      if (run && !run_last)
         run_rise_time = UUT.vita_time;
      run_last = run;
   end

   // ******************************
   // Helpers
   // ******************************
   task automatic check_equal(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic finish_run();
      error_count += UUT.control.control_checks.fail_count;
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   endtask

   task automatic report_timeout(input string what);
      error_count++;
      $display("Timed out waiting for %s", what);
   endtask

   function automatic tuser_t make_tuser(input logic [11:0] seq, input logic eob,
                                         input logic timed, input logic [63:0] when);
      tuser_t t;
      t          = '0;
      t[63:0]    = when;
      t[123:112] = seq;
      t[124]     = eob;
      t[125]     = timed;
      return t;
   endfunction

   function automatic logic [63:0] make_code(input logic [31:0] cls,
                                             input logic [11:0] exp_seq,
                                             input logic [11:0] rcv_seq);
      logic [63:0] c;
      c        = '0;
      c[63:32] = cls;
      c[27:16] = exp_seq;
      c[11:0]  = rcv_seq;
      return c;
   endfunction

   task automatic write_setting(input int addr, input logic [31:0] data);
      set_stb  = 1'b1;
      set_addr = `SR_ADDR_W'(addr);
      set_data = data;
      @(negedge clk);
      set_stb  = 1'b0;
      @(negedge clk);                      // Policy side effects settle.
   endtask

   // Ready does not depend on the stream inputs, so it is read here.
   task automatic send_word(input tuser_t user, input logic last, input logic play);
      int waited;
      waited    = 0;
      tx_tdata  = $random(seed);
      tx_tuser  = user;
      tx_tlast  = last;
      tx_tvalid = 1'b1;
      if (play)
         expect_q.push_back(tx_tdata);
      while (!tx_tready && waited < timeout_cycles)
      begin
         @(negedge clk);
         waited++;
      end
      if (!tx_tready)
         report_timeout("tx_tready");
      @(negedge clk);
      check_equal("seqnum", seqnum, user[123:112]);
   endtask

   task automatic send_packet(input logic [11:0] seq, input int words, input logic eob,
                              input logic timed, input logic [63:0] when, input logic play);
      for (int i = 0; i < words; i++)
         send_word(make_tuser(seq, eob, timed, when), i == words - 1, play);
      tx_tvalid = 1'b0;
      tx_tlast  = 1'b0;
   endtask

   task automatic expect_error(input logic [63:0] code);
      int waited;
      waited = 0;
      while (code_q.size() == 0 && waited < timeout_cycles)
      begin
         @(negedge clk);
         waited++;
      end
      if (code_q.size() == 0)
         report_timeout("an error report");
      else
         check_equal("error_code", code_q.pop_front(), code);
   endtask

   task automatic check_played();
      check_equal("played word count", played_q.size(), expect_q.size());
      while (played_q.size() > 0 && expect_q.size() > 0)
         check_equal("sample", played_q.pop_front(), expect_q.pop_front());
      check_equal("unexpected error reports", code_q.size(), 0);
      played_q.delete();
      expect_q.delete();
      code_q.delete();
   endtask

   // ******************************
   // Directed tests
   // ******************************
   task automatic test_immediate_burst();
      write_setting(`SR_INTERP, 32'd2);
      write_setting(`SR_ERROR_POLICY, 32'b010);   // Next packet.
      send_packet(12'd0, 3, 1'b0, 1'b0, 64'd0, 1'b1);
      send_packet(12'd1, 3, 1'b1, 1'b0, 64'd0, 1'b1);
      expect_error(make_code(32'd1, 12'd0, 12'd1));
      check_played();
   endtask

   task automatic test_timed_burst();
      vita_time_t base;
      base = 64'h0000_0001_0000_0100;
      write_setting(`SR_ERROR_POLICY, 32'b010);
      write_setting(`SR_TIME_LO, base[31:0]);
      write_setting(`SR_TIME_HI, base[63:32]);
      run_rise_time = '0;
      send_packet(12'd0, 2, 1'b1, 1'b1, base + 64'd60, 1'b1);
      check_equal("vita_time after run rise", run_rise_time, base + 64'd61);
      expect_error(make_code(32'd1, 12'd0, 12'd0));
      send_packet(12'd1, 2, 1'b0, 1'b1, base + 64'd10, 1'b0);   // Already past.
      expect_error(make_code(32'd8, 12'd0, 12'd1));
      check_played();
   endtask

   task automatic test_seq_error_start();
      send_packet(12'd5, 2, 1'b0, 1'b0, 64'd0, 1'b0);
      expect_error(make_code(32'd4, 12'd2, 12'd5));
      send_packet(12'd6, 3, 1'b1, 1'b0, 64'd0, 1'b1);
      expect_error(make_code(32'd1, 12'd0, 12'd6));
      check_played();
   endtask

   task automatic test_underrun();
      tuser_t user;
      user = make_tuser(12'd7, 1'b0, 1'b0, 64'd0);
      send_word(user, 1'b0, 1'b1);
      send_word(user, 1'b0, 1'b1);
      tx_tvalid = 1'b0;                     // Gap at the next strobe.
      expect_error(make_code(32'd2, 12'd0, 12'd7));
      check_equal("run", run, 1'b0);
      send_word(user, 1'b0, 1'b0);
      send_word(user, 1'b1, 1'b0);
      tx_tvalid = 1'b0;
      check_played();
   endtask

   task automatic test_midburst_wait();
      tuser_t jump;
      jump = make_tuser(12'd3, 1'b0, 1'b0, 64'd0);
      write_setting(`SR_ERROR_POLICY, 32'b001);   // Wait.
      send_packet(12'd0, 2, 1'b0, 1'b0, 64'd0, 1'b1);
      send_word(jump, 1'b0, 1'b1);            // Offending word goes out on its strobe.
      send_word(jump, 1'b0, 1'b0);
      send_word(jump, 1'b1, 1'b0);
      tx_tvalid = 1'b0;
      expect_error(make_code(32'd32, 12'd1, 12'd3));
      tx_tuser  = make_tuser(12'd4, 1'b0, 1'b0, 64'd0);
      tx_tlast  = 1'b1;
      tx_tvalid = 1'b1;
      repeat (20)
      begin
         @(negedge clk);
         check_equal("tx_tready", tx_tready, 1'b0);
         check_equal("run", run, 1'b0);
      end
      tx_tvalid = 1'b0;
      tx_tlast  = 1'b0;
      clear     = 1'b1;
      @(negedge clk);
      clear     = 1'b0;
      send_packet(12'd0, 2, 1'b1, 1'b0, 64'd0, 1'b1);
      expect_error(make_code(32'd1, 12'd0, 12'd0));
      check_played();
   endtask

   initial
   begin
      reset     = 1'b1;
      clear     = 1'b0;
      set_stb   = 1'b0;
      set_addr  = '0;
      set_data  = '0;
      tx_tdata  = '0;
      tx_tuser  = '0;
      tx_tlast  = 1'b0;
      tx_tvalid = 1'b0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      test_immediate_burst();
      test_timed_burst();
      test_seq_error_start();
      test_underrun();
      test_midburst_wait();
      finish_run();
   end

endmodule

/* tests/tx_core_assert.sv */
// ******************************
// Bound checks on the transmit
// controller outputs.
// ******************************
module tx_core_assert
(
   input logic                     clk,
   input logic                     reset,
   input logic                     error,
   input logic                     run,
   input logic                     tx_tready,
   input logic                     strobe,
   input tx_status_pkg::tx_state_t state
);

   timeunit 1ns;
   timeprecision 1ps;

   import tx_status_pkg::*;

   int fail_count = 0;   // Failed assertions so far.

   // ******************************
   // Properties
   // ******************************
   error_single_pulse: assert property (@(posedge clk) disable iff (reset) error |=> !error)
   else
   begin
      $error("error pulse lasted two cycles");
      fail_count++;
   end

   // First reset edge only sets the state, so check from the second on.
   quiet_in_reset: assert property (@(posedge clk)
                                    (reset && $past(reset)) |-> (!run && !tx_tready))
   else
   begin
      $error("run or tx_tready high during reset");
      fail_count++;
   end

   // No strobe on the first cycle of a burst.
   ready_on_strobe: assert property (@(posedge clk) disable iff (reset)
                                     (state == st_sample && tx_tready) |-> (strobe && $past(run)))
   else
   begin
      $error("tx_tready high in the sample state without strobe");
      fail_count++;
   end

endmodule

bind tx_control tx_core_assert control_checks
(
   .clk(clk), .reset(reset), .error(error), .run(run),
   .tx_tready(tx_tready), .strobe(strobe), .state(state)
);

/* hw/tx_core.sv */
// ******************************
// Transmit subsystem top. Settings,
// time base, strobe and controller.
// ******************************
`include "tx_defs.svh"

module tx_core
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       clear,
   input  logic                       set_stb,
   input  logic [`SR_ADDR_W-1:0]      set_addr,
   input  logic [`SR_DATA_W-1:0]      set_data,
   input  tx_stream_pkg::sample_t     tx_tdata,
   input  tx_stream_pkg::tuser_t      tx_tuser,
   input  logic                       tx_tlast,
   input  logic                       tx_tvalid,
   output logic                       tx_tready,
   output logic                       run,
   output tx_stream_pkg::sample_t     sample,
   output logic                       error,
   output tx_status_pkg::error_code_t error_code,
   output tx_stream_pkg::seqnum_t     seqnum
);

   import tx_stream_pkg::*;

   logic [`INTERP_W-1:0]  interp_rate;
   logic [`SR_DATA_W-1:0] time_lo;
   logic [`SR_DATA_W-1:0] time_hi;
   logic                  time_load;
   vita_time_t            load_time;
   vita_time_t            vita_time;
   vita_time_t            send_time;
   logic                  now;
   logic                  late;
   logic                  strobe;

   assign load_time = {time_hi, time_lo};

   // ******************************
   // Settings registers
   // ******************************
   setting_reg #(.my_addr(`SR_INTERP), .width(`INTERP_W)) sr_interp
   (
      .clk(clk), .reset(reset), .strobe(set_stb), .addr(set_addr),
      .in(set_data), .out(interp_rate), .changed()
   );

   setting_reg #(.my_addr(`SR_TIME_LO), .width(`SR_DATA_W)) sr_time_lo
   (
      .clk(clk), .reset(reset), .strobe(set_stb), .addr(set_addr),
      .in(set_data), .out(time_lo), .changed()
   );

   // High word write triggers the load.
   setting_reg #(.my_addr(`SR_TIME_HI), .width(`SR_DATA_W)) sr_time_hi
   (
      .clk(clk), .reset(reset), .strobe(set_stb), .addr(set_addr),
      .in(set_data), .out(time_hi), .changed(time_load)
   );

   // ******************************
   // Time base and sample strobe
   // ******************************
   vita_timekeeper timekeeper
   (
      .clk(clk), .reset(reset), .load(time_load), .load_time(load_time),
      .send_time(send_time), .vita_time(vita_time), .now(now), .late(late)
   );

   dsp_strobe_gen strobe_gen
   (
      .clk(clk), .reset(reset), .run(run), .rate(interp_rate), .strobe(strobe)
   );

   tx_control control
   (
      .clk(clk), .reset(reset), .clear(clear),
      .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
      .vita_time(vita_time), .now(now), .late(late), .send_time(send_time),
      .tx_tdata(tx_tdata), .tx_tuser(tx_tuser), .tx_tlast(tx_tlast),
      .tx_tvalid(tx_tvalid), .tx_tready(tx_tready),
      .error(error), .seqnum(seqnum), .error_code(error_code),
      .run(run), .sample(sample), .strobe(strobe)
   );

endmodule

/* hw/tx_control.sv */
// ******************************
// Transmit burst controller with
// sequence checks and error policy.
// ******************************
`include "tx_defs.svh"

module tx_control
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       clear,
   input  logic                       set_stb,
   input  logic [`SR_ADDR_W-1:0]      set_addr,
   input  logic [`SR_DATA_W-1:0]      set_data,
   input  tx_stream_pkg::vita_time_t  vita_time,
   input  logic                       now,
   input  logic                       late,
   output tx_stream_pkg::vita_time_t  send_time,
   input  tx_stream_pkg::sample_t     tx_tdata,
   input  tx_stream_pkg::tuser_t      tx_tuser,
   input  logic                       tx_tlast,
   input  logic                       tx_tvalid,
   output logic                       tx_tready,
   output logic                       error,
   output tx_stream_pkg::seqnum_t     seqnum,
   output tx_status_pkg::error_code_t error_code,
   output logic                       run,
   output tx_stream_pkg::sample_t     sample,
   input  logic                       strobe
);

   import tx_stream_pkg::*;
   import tx_status_pkg::*;

   tx_state_t   state;
   seqnum_t     expected_seqnum;
   logic        eob;
   logic        send_at;
   logic        seq_ok;
   logic        policy_wait;
   logic        policy_next_packet;
   logic        policy_next_burst;
   logic        clear_seqnum;
   logic [31:0] seq_only;
   logic [31:0] seq_pair;

   // ******************************
   // Sideband fields
   // ******************************
   assign seqnum  = tx_tuser[seq_lsb +: $bits(seqnum_t)];
   assign eob     = tx_tuser[eob_bit];
   assign send_at = tx_tuser[send_at_bit];

   // Untimed packets track the counter, so the compare stays quiet.
   assign send_time = send_at ? tx_tuser[time_lsb +: $bits(vita_time_t)] : vita_time;

   assign seq_ok   = (seqnum == expected_seqnum);
   assign seq_only = {20'd0, seqnum};
   assign seq_pair = {4'd0, expected_seqnum, 4'd0, seqnum};

   // Policy bits: next burst, next packet, wait.
   setting_reg
   #(
      .my_addr  (`SR_ERROR_POLICY),
      .width    (3),
      .at_reset (3'b000)
   )
   sr_error_policy
   (
      .clk     (clk),
      .reset   (reset),
      .strobe  (set_stb),
      .addr    (set_addr),
      .in      (set_data),
      .out     ({policy_next_burst, policy_next_packet, policy_wait}),
      .changed (clear_seqnum)
   );

   // ******************************
   // Expected sequence number
   // ******************************
   always_ff @(posedge clk)
   begin
      if (reset || clear || clear_seqnum)
         expected_seqnum <= '0;
      else if (tx_tvalid && tx_tready && tx_tlast)
         expected_seqnum <= seqnum + 1'b1;   // Next packet follows this one.
   end

   // ******************************
   // Burst FSM
   // ******************************
   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         state      <= st_idle;
         error      <= 1'b0;
         error_code <= '0;
      end
      else
      begin
         error <= 1'b0;
         case (state)
            st_idle:
               if (tx_tvalid)
               begin
                  if (!seq_ok)
                  begin
                     state      <= st_error;
                     error      <= 1'b1;
                     error_code <= {code_seq_error, seq_pair};
                  end
                  else if (!send_at || now)
                     state <= st_sample;            // Burst starts.
                  else if (late)
                  begin
                     state      <= st_error;
                     error      <= 1'b1;
                     error_code <= {code_time_error, seq_only};
                  end
               end

            st_sample:
               if (strobe)
               begin
                  if (!tx_tvalid)
                  begin
                     state      <= st_error;
                     error      <= 1'b1;
                     error_code <= {code_underrun, seq_only};
                  end
                  else if (!seq_ok)
                  begin
                     state      <= st_error;
                     error      <= 1'b1;
                     error_code <= {code_seq_error_midburst, seq_pair};
                  end
                  else if (tx_tlast && eob)
                  begin
                     state      <= st_idle;
                     error      <= 1'b1;
                     error_code <= {code_eob_ack, seq_only};
                  end
               end

            st_error:
               if (tx_tvalid && tx_tlast)           // Drop up to end of packet.
               begin
                  if (policy_next_packet || (policy_next_burst && eob))
                     state <= st_idle;
                  else if (policy_wait)
                     state <= st_wait;
               end

            st_wait:
               state <= st_wait;                    // Held until clear.

            default:
               state <= st_idle;
         endcase
      end
   end

   // ******************************
   // Outputs to the DSP core
   // ******************************
   assign run       = (state == st_sample);
   assign tx_tready = (state == st_error) || (run && strobe);
   assign sample    = tx_tdata;

endmodule

/* hw/dsp_strobe_gen.sv */
// ******************************
// Sample strobe at the programmed
// interpolation rate.
// ******************************
`include "tx_defs.svh"

module dsp_strobe_gen
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 run,
   input  logic [`INTERP_W-1:0] rate,
   output logic                 strobe
);

   logic [`INTERP_W-1:0] count;
   logic [`INTERP_W-1:0] count_next;

   // Reload on zero, else count down.
   assign count_next = (count == '0) ? rate : count - 1'b1;

   always_ff @(posedge clk)
   begin
      if (reset || !run)
      begin
         count  <= '0;                    // Parked until the burst starts.
         strobe <= 1'b0;
      end
      else
      begin
         count  <= count_next;
         strobe <= (count_next == '0);
      end
   end

endmodule

/* hw/vita_timekeeper.sv */
// ******************************
// Radio time base. Counts every
// cycle and compares to send time.
// ******************************
module vita_timekeeper
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      load,
   input  tx_stream_pkg::vita_time_t load_time,
   input  tx_stream_pkg::vita_time_t send_time,
   output tx_stream_pkg::vita_time_t vita_time,
   output logic                      now,
   output logic                      late
);

   // ******************************
   // Time counter
   // ******************************
   always_ff @(posedge clk)
   begin
      if (reset)
         vita_time <= '0;
      else if (load)
         vita_time <= load_time;          // Counts on from the loaded value.
      else
         vita_time <= vita_time + 64'd1;
   end

   // ******************************
   // Send time compare
   // ******************************
   assign now  = (vita_time == send_time);
   assign late = (vita_time > send_time);   // Send time already passed.

endmodule

/* hw/setting_reg.sv */
// ******************************
// Settings bus register. Captures
// a field written to its address.
// ******************************
`include "tx_defs.svh"

module setting_reg
#(
   parameter int               my_addr  = 0,
   parameter int               width    = 32,
   parameter logic [width-1:0] at_reset = '0
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  strobe,
   input  logic [`SR_ADDR_W-1:0] addr,
   input  logic [`SR_DATA_W-1:0] in,
   output logic [width-1:0]      out,
   output logic                  changed
);

   logic hit;

   assign hit = strobe && (addr == `SR_ADDR_W'(my_addr));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out     <= at_reset;
         changed <= 1'b0;
      end
      else
      begin
         changed <= hit;                  // One pulse per write.
         if (hit)
            out <= in[width-1:0];
      end
   end

endmodule

/* hw/tx_status_pkg.sv */
// ******************************
// Transmit controller states and
// error report encoding.
// ******************************
package tx_status_pkg;

   typedef enum logic [1:0]
   {
      st_idle   = 2'd0,
      st_sample = 2'd1,
      st_error  = 2'd2,
      st_wait   = 2'd3
   } tx_state_t;

   typedef logic [63:0] error_code_t;   // Class in 63:32, detail in 31:0.
   typedef logic [31:0] error_class_t;

   // Error classes.
   localparam error_class_t code_eob_ack            = 32'd1;
   localparam error_class_t code_underrun           = 32'd2;
   localparam error_class_t code_seq_error          = 32'd4;
   localparam error_class_t code_time_error         = 32'd8;
   localparam error_class_t code_seq_error_midburst = 32'd32;

endpackage

/* hw/tx_stream_pkg.sv */
// ******************************
// Sample stream types and sideband
// field positions.
// ******************************
package tx_stream_pkg;

   typedef logic [31:0]  sample_t;      // One I/Q sample word.
   typedef logic [127:0] tuser_t;       // Sideband word.
   typedef logic [11:0]  seqnum_t;      // Packet sequence number.
   typedef logic [63:0]  vita_time_t;   // Radio time in ticks.

   // ******************************
   // Sideband layout
   // ******************************
   localparam int time_lsb    = 0;      // Send time, 63:0.
   localparam int seq_lsb     = 112;    // Sequence number, 123:112.
   localparam int eob_bit     = 124;    // End of burst.
   localparam int send_at_bit = 125;    // Timed send.

endpackage

/* hw/tx_defs.svh */
// ******************************
// Transmit subsystem settings map
// and field widths.
// ******************************
`ifndef TX_DEFS_SVH
`define TX_DEFS_SVH

// Settings bus addresses.
`define SR_ERROR_POLICY 0
`define SR_INTERP       1
`define SR_TIME_LO      2
`define SR_TIME_HI      3

`define SR_ADDR_W 8     // Settings address width.
`define SR_DATA_W 32    // Settings data width.

`define INTERP_W 8      // Interpolation rate field.

`endif
